// File: Makefile
# Verilator build and run of the elink transmit testbench

TOP             ?= tb_tra_elink
SIM_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f src.f
	@out="$$(./$(SIM_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(SIM_DIR)

// File: axil_msg_capture.sv
// AXI4-Lite slave with the ten byte message buffer
// readback, status, and commit of the message into the stream
module axil_msg_capture (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [31:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  stream_if.source    msg_s
);
  import can_msg_pkg::*;

  msg_byte_t  regs [NUM_BYTES];
  logic [4:0] w_idx;
  logic [4:0] r_idx;
  logic [4:0] w_off;
  logic [4:0] r_off;
  logic       w_hs;
  logic       ar_hs;
  logic       commit_done;

  assign w_idx = awaddr[6:2];
  assign r_idx = araddr[6:2];
  assign w_off = w_idx - IDX_FIRST;   // byte number within the buffer
  assign r_off = r_idx - IDX_FIRST;

  assign w_hs        = awready && awvalid && wvalid;
  assign ar_hs       = arready && arvalid;
  assign commit_done = msg_s.valid && msg_s.ready;

  assign wready = awready;   // address and data taken together

  // no writes are accepted while a commit waits, so the buffer
  // itself serves as the stream payload
  assign msg_s.payload = '{
    b0:   regs[0],
    b1:   regs[1],
    b2:   regs[2],
    b3:   regs[3],
    b4:   regs[4],
    b5:   regs[5],
    b6:   regs[6],
    b7:   regs[7],
    b8:   regs[8],
    tail: regs[9][3:0]
  };

  // write channel, byte registers and commit
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      awready     <= 1'b0;
      bvalid      <= 1'b0;
      bresp       <= RESP_OKAY;
      msg_s.valid <= 1'b0;
      for (int i = 0; i < NUM_BYTES; i++)
        regs[i] <= '0;
    end
    else
    begin
      // one cycle pulse, only when nothing is pending
      awready <= awvalid && wvalid && !awready && !bvalid && !msg_s.valid;

      if (bvalid && bready)
        bvalid <= 1'b0;

      if (w_hs)
      begin
        if (w_idx >= IDX_FIRST && w_idx <= IDX_LAST)
        begin
          if (wstrb[0])
            regs[w_off[3:0]] <= wdata[7:0];
          bvalid <= 1'b1;
          bresp  <= RESP_OKAY;
        end
        else if (w_idx == IDX_COMMIT)
        begin
          msg_s.valid <= 1'b1;   // response waits for the packer
        end
        else if (w_idx == IDX_STATUS)
        begin
          bvalid <= 1'b1;        // read only, write ignored
          bresp  <= RESP_OKAY;
        end
        else
        begin
          // undefined index wipes the whole buffer
          for (int i = 0; i < NUM_BYTES; i++)
            regs[i] <= '0;
          bvalid <= 1'b1;
          bresp  <= RESP_SLVERR;
        end
      end

      if (commit_done)
      begin
        msg_s.valid <= 1'b0;
        bvalid      <= 1'b1;
        bresp       <= RESP_OKAY;
      end
    end
  end

  // read channel handshake
  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end
    else
    begin
      arready <= arvalid && !arready && !rvalid;
      if (rvalid && rready)
        rvalid <= 1'b0;
      if (ar_hs)
        rvalid <= 1'b1;
    end
  end

  // read data
  always_ff @(posedge clk)
  begin
    if (ar_hs)
    begin
      if (r_idx >= IDX_FIRST && r_idx <= IDX_LAST)
      begin
        rdata <= {24'h0, regs[r_off[3:0]]};
        rresp <= RESP_OKAY;
      end
      else if (r_idx == IDX_STATUS)
      begin
        rdata <= {31'h0, msg_s.valid};   // commit waiting
        rresp <= RESP_OKAY;
      end
      else
      begin
        rdata <= '0;
        rresp <= RESP_SLVERR;
      end
    end
  end

  // host keeps seeing the same response until it takes it
  a_b_hold: assert property (@(posedge clk) disable iff (!rst)
    bvalid && !bready |=> bvalid && $stable(bresp));

  // committed message stays put until the packer takes it
  a_msg_hold: assert property (@(posedge clk) disable iff (!rst)
    msg_s.valid && !msg_s.ready |=> msg_s.valid && $stable(msg_s.payload));

endmodule

// File: can_msg_pkg.sv
// CAN message byte and 76-bit message types
// register word indexes and AXI response codes
package can_msg_pkg;

  // one byte register of the buffer
  typedef logic [7:0] msg_byte_t;

  // nine full bytes, then the low nibble of b9
  typedef struct packed {
    msg_byte_t  b0;
    msg_byte_t  b1;
    msg_byte_t  b2;
    msg_byte_t  b3;
    msg_byte_t  b4;
    msg_byte_t  b5;
    msg_byte_t  b6;
    msg_byte_t  b7;
    msg_byte_t  b8;
    logic [3:0] tail;
  } can_msg_t;

  localparam int NUM_BYTES = 10;    // b0 to b9

  // word index, taken from address bits 6:2
  localparam logic [4:0] IDX_FIRST  = 5'd2;    // b0
  localparam logic [4:0] IDX_LAST   = 5'd11;   // b9
  localparam logic [4:0] IDX_COMMIT = 5'd12;
  localparam logic [4:0] IDX_STATUS = 5'd13;   // bit 0 is commit waiting

  // AXI write and read response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: elink_pkg.sv
// elink word type and control characters
// transmit frame and its length in words
package elink_pkg;

  typedef struct packed {
    logic       k;       // control character flag
    logic [7:0] data;
  } elink_word_t;

  localparam elink_word_t K_SOP = '{k: 1'b1, data: 8'h3C};
  localparam elink_word_t K_EOP = '{k: 1'b1, data: 8'hDC};

  typedef struct packed {
    can_msg_pkg::can_msg_t msg;
    logic [7:0]            csum;   // sum of the ten sent bytes, mod 256
  } elink_frame_t;

  // SOP, ten data bytes, checksum, EOP
  localparam int FRAME_WORDS = 13;

endpackage

// File: elink_serializer.sv
// sends one frame as SOP, ten data bytes, checksum and EOP
// on an 8-bit elink word stream with k flag
module elink_serializer (
  input  logic                   clk,
  input  logic                   rst,
  stream_if.sink                 frame_s,
  output elink_pkg::elink_word_t elink_data,
  output logic                   elink_valid,
  input  logic                   elink_ready
);
  import elink_pkg::*;

  localparam logic [3:0] LAST_WORD = 4'(FRAME_WORDS - 1);

  elink_frame_t cur;            // frame on the wire
  logic [7:0]   body [11];      // data bytes then checksum
  logic [3:0]   word_cnt;
  logic [3:0]   body_idx;
  logic         busy;
  logic         word_hs;
  logic         take;

  assign word_hs  = busy && elink_ready;
  assign body_idx = word_cnt - 4'd1;

  // next frame may load in the cycle EOP goes out
  assign frame_s.ready = !busy || (elink_ready && word_cnt == LAST_WORD);
  assign take          = frame_s.valid && frame_s.ready;
  assign elink_valid   = busy;

  always_comb
  begin
    body[0]  = cur.msg.b0;
    body[1]  = cur.msg.b1;
    body[2]  = cur.msg.b2;
    body[3]  = cur.msg.b3;
    body[4]  = cur.msg.b4;
    body[5]  = cur.msg.b5;
    body[6]  = cur.msg.b6;
    body[7]  = cur.msg.b7;
    body[8]  = cur.msg.b8;
    body[9]  = {4'h0, cur.msg.tail};   // tenth byte, nibble only
    body[10] = cur.csum;
  end

  // word select
  always_comb
  begin
    if (word_cnt == 4'd0)
      elink_data = K_SOP;
    else if (word_cnt == LAST_WORD)
      elink_data = K_EOP;
    else
    begin
      elink_data.k    = 1'b0;
      elink_data.data = body[body_idx];
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
      cur <= frame_s.payload;
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      busy     <= 1'b0;
      word_cnt <= '0;
    end
    else
    begin
      if (take)
      begin
        busy     <= 1'b1;
        word_cnt <= '0;   // SOP on the next cycle
      end
      else if (word_hs)
      begin
        if (word_cnt == LAST_WORD)
          busy <= 1'b0;
        else
          word_cnt <= word_cnt + 4'd1;
      end
    end
  end

  // stalled word must not change under the receiver
  a_word_hold: assert property (@(posedge clk) disable iff (!rst)
    elink_valid && !elink_ready |=> elink_valid && $stable(elink_data));

endmodule

// File: frame_packer.sv
// circular message queue between capture and serializer
// checksum is added as each message is pushed
module frame_packer #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic     clk,
  input  logic     rst,
  stream_if.sink   msg_s,
  stream_if.source frame_s
);
  import can_msg_pkg::*;
  import elink_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(QUEUE_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(QUEUE_DEPTH);

  elink_frame_t     queue [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;     // frames held
  logic             push;
  logic             pop;

  // sum of the ten sent bytes, tail nibble with upper nibble zero
  function automatic logic [7:0] msg_checksum(can_msg_t m);
    logic [7:0] sum;
    sum = m.b0 + m.b1 + m.b2 + m.b3 + m.b4 + m.b5 + m.b6 + m.b7 + m.b8;
    sum = sum + {4'h0, m.tail};
    return sum;
  endfunction

  assign push = msg_s.valid && msg_s.ready;
  assign pop  = frame_s.valid && frame_s.ready;

  assign msg_s.ready     = (count != FULL_CNT);
  assign frame_s.valid   = (count != '0);
  assign frame_s.payload = queue[rd_ptr];   // head of queue

  always_ff @(posedge clk)
  begin
    if (push)
      queue[wr_ptr] <= '{msg: msg_s.payload, csum: msg_checksum(msg_s.payload)};
  end

  always_ff @(posedge clk)
  begin
    if (!rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;

      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // when full the write pointer has caught up with the head,
  // so a push here would overwrite an unsent frame
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
    count == FULL_CNT |-> wr_ptr == rd_ptr && !push);

endmodule

// File: src.f
can_msg_pkg.sv
elink_pkg.sv
stream_if.sv
axil_msg_capture.sv
frame_packer.sv
elink_serializer.sv
tra_elink_top.sv
tb_tra_elink.sv

// File: stream_if.sv
// valid/ready stream with a typed payload
interface stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t payload;

  // producer side, holds valid and payload until the transfer
  modport source (
    output valid,
    output payload,
    input  ready
  );

  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: tb_tra_elink.sv
// directed testbench for the CAN to elink transmit bridge
// clock, LFSR, AXI tasks, compare tasks, output monitor and watchdog
module tb_tra_elink;
  import can_msg_pkg::*;
  import elink_pkg::*;

  localparam int QUEUE_DEPTH = 2;
  localparam int NUM_TESTS   = 5;

  logic        clk;
  logic        rst;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  elink_word_t elink_data;
  logic        elink_valid;
  logic        elink_ready;

  int           errors;
  int           checks;
  int           ready_mode;              // 0 low, 1 high, 2 random
  int           word_idx;                // next word of the frame on the wire
  logic [15:0]  msg_lfsr;
  logic [15:0]  rdy_lfsr;
  msg_byte_t    cur_bytes [NUM_BYTES];   // expected buffer contents
  elink_frame_t exp_frames [$];

  tra_elink_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .awaddr      (awaddr),
    .awvalid     (awvalid),
    .awready     (awready),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .wvalid      (wvalid),
    .wready      (wready),
    .bresp       (bresp),
    .bvalid      (bvalid),
    .bready      (bready),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .arready     (arready),
    .rdata       (rdata),
    .rresp       (rresp),
    .rvalid      (rvalid),
    .rready      (rready),
    .elink_data  (elink_data),
    .elink_valid (elink_valid),
    .elink_ready (elink_ready)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // galois LFSR, one step
  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(inout logic [15:0] s, input int n, output logic [7:0] v);
    v = 8'h0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[6:0], s[0]};
      s = lfsr_step(s);
    end
  endtask

  task automatic check_word(string name, elink_word_t exp, elink_word_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_byte(string name, msg_byte_t exp, msg_byte_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(string name, logic [1:0] exp, logic [1:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // word idx of a frame, SOP first and EOP last
  function automatic elink_word_t frame_word(elink_frame_t f, int idx);
    logic [75:0] bits;
    elink_word_t w;
    bits = f.msg;
    w.k  = 1'b0;
    w.data = 8'h0;
    if (idx == 0)
      w = K_SOP;
    else if (idx <= 9)
      w.data = bits[83 - 8 * idx -: 8];   // b0 sits at the top
    else if (idx == 10)
      w.data = {4'h0, bits[3:0]};
    else if (idx == 11)
      w.data = f.csum;
    else
      w = K_EOP;
    return w;
  endfunction

  task automatic push_expected();
    elink_frame_t f;
    logic [7:0]   sum;
    sum = 8'h0;
    for (int i = 0; i < 9; i++)
      sum = sum + cur_bytes[i];
    sum = sum + {4'h0, cur_bytes[9][3:0]};
    f.msg = {cur_bytes[0], cur_bytes[1], cur_bytes[2], cur_bytes[3], cur_bytes[4],
             cur_bytes[5], cur_bytes[6], cur_bytes[7], cur_bytes[8], cur_bytes[9][3:0]};
    f.csum = sum;
    exp_frames.push_back(f);
  endtask

  // address and data phase only
  task automatic send_write(input logic [4:0] idx, input logic [31:0] data);
    int n;
    n = 0;
    awaddr  = {25'h0, idx, 2'b00};
    wdata   = data;
    wstrb   = 4'hF;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!(awready || wready) && n < 200)
    begin
      @(negedge clk);
      n++;
    end
    if (n == 200)
    begin
      errors++;
      $display("write address to index %0d was never accepted", idx);
    end
    else if (!(awready && wready))
    begin
      errors++;
      $display("awready and wready did not rise together for index %0d", idx);
    end
    @(negedge clk);   // handshake done on the edge before
    awvalid = 1'b0;
    wvalid  = 1'b0;
  endtask

  task automatic wait_resp(output logic [1:0] resp, input int limit, output logic got);
    int n;
    n = 0;
    while (!bvalid && n < limit)
    begin
      @(negedge clk);
      n++;
    end
    got  = bvalid;
    resp = bresp;
    if (got)
      @(negedge clk);   // bready is always high
  endtask

  task automatic axil_write(input logic [4:0] idx, input logic [31:0] data,
                            input logic [1:0] exp_resp);
    logic [1:0] resp;
    logic       got;
    send_write(idx, data);
    wait_resp(resp, 400, got);
    if (!got)
    begin
      errors++;
      $display("no write response for index %0d", idx);
    end
    else
      check_resp("bresp", exp_resp, resp);
  endtask

  task automatic axil_read(input logic [4:0] idx, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    n = 0;
    araddr  = {25'h0, idx, 2'b00};
    arvalid = 1'b1;
    while (!arready && n < 200)
    begin
      @(negedge clk);
      n++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid && n < 400)
    begin
      @(negedge clk);
      n++;
    end
    if (n >= 200)
    begin
      errors++;
      $display("read of index %0d got no data", idx);
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
  endtask

  task automatic read_check(input logic [4:0] idx, input msg_byte_t exp,
                            input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(idx, data, resp);
    check_byte("rdata", exp, data[7:0]);
    checks++;
    if (data[31:8] !== 24'h0)   // only the low byte carries data
    begin
      errors++;
      $display("[FAIL] %0t rdata[31:8] expected 000000 got %h", $time, data[31:8]);
    end
    check_resp("rresp", exp_resp, resp);
  endtask

  task automatic fill_random();
    logic [7:0] b;
    for (int i = 0; i < NUM_BYTES; i++)
    begin
      take_bits(msg_lfsr, 8, b);
      cur_bytes[i] = b;
      axil_write(5'(IDX_FIRST + i), {24'h0, b}, RESP_OKAY);
    end
  endtask

  task automatic commit();
    push_expected();   // queued before the frame can appear
    axil_write(IDX_COMMIT, 32'h0, RESP_OKAY);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((exp_frames.size() != 0 || word_idx != 0 || elink_valid) && n < 2000)
    begin
      @(negedge clk);
      n++;
    end
    if (n == 2000)
    begin
      errors++;
      $display("expected frames did not leave the elink port");
    end
  endtask

  task automatic test_readback();
    fill_random();
    for (int i = 0; i < NUM_BYTES; i++)
      read_check(5'(IDX_FIRST + i), cur_bytes[i], RESP_OKAY);
  endtask

  task automatic test_single_frame();
    ready_mode = 1;
    commit();
    wait_drain();
  endtask

  task automatic test_clear();
    axil_write(5'd20, 32'hFF, RESP_SLVERR);
    for (int i = 0; i < NUM_BYTES; i++)
      cur_bytes[i] = 8'h0;
    for (int i = 0; i < NUM_BYTES; i++)
      read_check(5'(IDX_FIRST + i), 8'h0, RESP_OKAY);
    read_check(5'd1, 8'h0, RESP_SLVERR);
  endtask

  task automatic test_backpressure();
    ready_mode = 2;
    repeat (4)
    begin
      fill_random();
      commit();
    end
    wait_drain();
  endtask

  // serializer plus a full queue, then one more commit must stall
  task automatic test_queue_full();
    logic [1:0] resp;
    logic       got;
    ready_mode = 0;
    repeat (QUEUE_DEPTH + 1)
    begin
      fill_random();
      commit();
    end
    fill_random();
    push_expected();
    send_write(IDX_COMMIT, 32'h0);
    wait_resp(resp, 40, got);
    if (got)
    begin
      errors++;
      $display("commit was answered while the queue was full");
    end
    read_check(IDX_STATUS, 8'h01, RESP_OKAY);
    ready_mode = 1;
    wait_resp(resp, 400, got);
    if (!got)
    begin
      errors++;
      $display("stalled commit never got its write response");
    end
    else
      check_resp("bresp", RESP_OKAY, resp);
    wait_drain();
    read_check(IDX_STATUS, 8'h00, RESP_OKAY);
  endtask

  // output monitor, also drives elink_ready
  initial
  begin
    logic [7:0]   r;
    logic         held;
    elink_word_t  held_word;
    elink_frame_t cur_frame;
    elink_ready = 1'b0;
    held        = 1'b0;
    held_word   = '0;
    cur_frame   = '0;
    word_idx    = 0;
    rdy_lfsr    = 16'd80;
    forever
    begin
      @(negedge clk);
      if (held)
      begin
        if (!elink_valid)
        begin
          errors++;
          $display("elink_valid dropped while a word was stalled");
        end
        check_word("elink_data held", held_word, elink_data);
      end
      // ready for the coming rising edge
      case (ready_mode)
        0: elink_ready = 1'b0;
        1: elink_ready = 1'b1;
        default:
        begin
          take_bits(rdy_lfsr, 1, r);
          elink_ready = r[0];
        end
      endcase
      if (elink_valid && elink_ready)
      begin
        if (word_idx == 0)
        begin
          if (exp_frames.size() == 0)
          begin
            errors++;
            $display("elink frame started with none expected");
          end
          else
            cur_frame = exp_frames.pop_front();
        end
        check_word("elink_data", frame_word(cur_frame, word_idx), elink_data);
        word_idx = (word_idx == FRAME_WORDS - 1) ? 0 : word_idx + 1;
      end
      held      = elink_valid && !elink_ready;
      held_word = elink_data;
    end
  end

  initial
  begin
    repeat (NUM_TESTS * 2000) @(posedge clk);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin
    errors     = 0;
    checks     = 0;
    ready_mode = 0;
    msg_lfsr   = 16'd80;
    rst        = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = 4'h0;
    wvalid     = 1'b0;
    bready     = 1'b1;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b1;
    for (int i = 0; i < NUM_BYTES; i++)
      cur_bytes[i] = 8'h0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;

    test_readback();
    test_single_frame();
    test_clear();
    test_backpressure();
    test_queue_full();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: tra_elink_top.sv
// transmit side of the CAN to elink bridge
// AXI4-Lite capture, frame packer and elink serializer in a chain
module tra_elink_top #(
  parameter int QUEUE_DEPTH = 2
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [31:0]            awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [31:0]            araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  output elink_pkg::elink_word_t elink_data,
  output logic                   elink_valid,
  input  logic                   elink_ready
);
  import can_msg_pkg::*;
  import elink_pkg::*;

  stream_if #(.payload_t(can_msg_t))     msg_s ();     // capture to packer
  stream_if #(.payload_t(elink_frame_t)) frame_s ();   // packer to serializer

  axil_msg_capture u_capture (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .msg_s   (msg_s.source)
  );

  frame_packer #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_packer (
    .clk     (clk),
    .rst     (rst),
    .msg_s   (msg_s.sink),
    .frame_s (frame_s.source)
  );

  elink_serializer u_serializer (
    .clk         (clk),
    .rst         (rst),
    .frame_s     (frame_s.sink),
    .elink_data  (elink_data),
    .elink_valid (elink_valid),
    .elink_ready (elink_ready)
  );

endmodule
